//--- bench/spi_input_vectors.txt
# name opcode wr_len rd_len write_bytes(hex, first byte left) slave_bytes(hex) stall_flag
# slave_bytes are returned in the read phase and are the expected upload data
write_only 11 03 00 a1b2c3 0 0
write_read 11 02 04 3c96 deadbeef 0
read_stall 11 01 05 7e 0102f0e1aa 1
read_only 11 00 03 0 55aa81 0
wrong_opcode 22 02 02 1234 9988 0
wr_too_long 11 0f 00 0 0 0
rd_too_long 11 01 11 c3 0 0
empty_xfer 11 00 00 0 0 0
full_write 11 0e 00 000102030405060708090a0b0c0d 0 0
max_read 11 00 10 0 00112233445566778899aabbccddeeff 1

//--- bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end
endmodule

//--- bench/tb_spi_bridge.sv
`timescale 1ns/10ps

module tb_spi_bridge;
    localparam logic [7:0] SPI_OPCODE = 8'h11;  // command routed to the bridge
    localparam logic [7:0] SPI_SOURCE = 8'h03;  // tag on every upload

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_cmd_type;
    logic [15:0] i_cmd_length;
    logic        i_cmd_start;
    logic [7:0]  i_cmd_data;
    logic [15:0] i_cmd_data_index;
    logic        i_cmd_data_valid;
    logic        i_cmd_done;
    logic        o_cmd_ready;
    logic        o_spi_clk;
    logic        o_spi_cs_n;
    logic        o_spi_mosi;
    logic        i_spi_miso;
    logic        i_upload_ready;
    logic        o_upload_valid;
    logic [7:0]  o_upload_data;
    logic [7:0]  o_upload_source;
    logic        o_upload_active;

    integer     seed = 32'h829f;
    int         errors = 0;
    int         checks = 0;
    bit         timed_out = 1'b0;
    bit         stall_mode = 1'b0;
    string      test_name = "reset";
    int         cs_falls = 0;
    logic [7:0] slave_resp [32];
    logic [7:0] mosi_q [$];
    logic [7:0] upload_q [$];
    logic [7:0] miso_sreg = 8'h00;
    logic [7:0] mosi_sreg = 8'h00;
    int         bit_cnt = 0;
    int         byte_k = 0;
    logic [7:0] held_data = 8'h00;
    bit         held_valid = 1'b0;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    spi_bridge dut (.*);

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // spi slave, mode 0
    assign i_spi_miso = miso_sreg[7];
    always @(negedge o_spi_cs_n) begin
        cs_falls++;
        bit_cnt   = 0;
        byte_k    = 0;
        miso_sreg = slave_resp[0];
    end
    always @(posedge o_spi_clk) begin
        assert (!o_spi_cs_n) else begin
            $display("sclk rose while chip select was high in test %s", test_name);
            errors++;
        end
        mosi_sreg = {mosi_sreg[6:0], o_spi_mosi};
        bit_cnt++;
        if (bit_cnt == 8) begin
            mosi_q.push_back(mosi_sreg);
            bit_cnt = 0;
            byte_k++;
        end
    end
    always @(negedge o_spi_clk) begin
        if (!o_spi_cs_n) begin
            if (bit_cnt == 0)
                miso_sreg = slave_resp[byte_k];  // next byte
            else
                miso_sreg = {miso_sreg[6:0], 1'b0};
        end
    end

    // upload ready, random stretches low when stalling
    always @(posedge clk) begin
        #1;
        if (stall_mode)
            i_upload_ready = (($random(seed) & 3) != 0);
        else
            i_upload_ready = 1'b1;
    end

    always @(posedge clk) begin
        if (rst_n && o_upload_valid) begin
            assert (i_upload_ready && o_upload_active && !o_cmd_ready) else begin
                $display("upload pulse with ready low, active low or command ready high in %s",
                         test_name);
                errors++;
            end
            check_value("upload source", 32'(SPI_SOURCE), 32'(o_upload_source));
            if (held_valid)
                check_value("upload data held", 32'(held_data), 32'(o_upload_data));
            held_valid = 1'b0;
            upload_q.push_back(o_upload_data);
        end else if (rst_n && o_upload_active && !i_upload_ready) begin
            if (held_valid)
                check_value("upload data held", 32'(held_data), 32'(o_upload_data));
            held_data  = o_upload_data;  // next byte must not move while stalled
            held_valid = 1'b1;
        end else if (!o_upload_active) begin
            held_valid = 1'b0;
        end
    end

    task automatic wait_cmd_ready(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 5000; n++) begin
            @(posedge clk);
            if (o_cmd_ready) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("timeout, command ready never came back in test %s", test_name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_vector(input logic [7:0] op, input logic [7:0] wr, input logic [7:0] rd,
                              input logic [127:0] wdata, input logic [127:0] rdata,
                              input int stall);
        int         nw;
        int         i;
        int         falls0;
        bit         ok;
        bit         valid;
        logic [7:0] exp_mosi [$];
        logic [7:0] exp_up [$];
        logic [7:0] wbytes [14];
        nw = (wr > 8'd14) ? 0 : int'(wr);
        valid = (op == SPI_OPCODE) && (int'(wr) + 2 <= 16) && (rd <= 8'd16);
        for (i = 0; i < nw; i++)
            wbytes[i] = wdata[8*(nw-1-i) +: 8];
        for (i = 0; i < 32; i++) begin
            if (i < int'(wr))
                slave_resp[i] = 8'h5a ^ 8'(i);  // filler during the write phase
            else if ((i - int'(wr) < int'(rd)) && (rd <= 8'd16))
                slave_resp[i] = rdata[8*(int'(rd)-1-(i-int'(wr))) +: 8];
            else
                slave_resp[i] = 8'h00;
        end
        if (valid) begin
            for (i = 0; i < nw; i++)
                exp_mosi.push_back(wbytes[i]);
            for (i = 0; i < int'(rd); i++) begin
                exp_mosi.push_back(8'h00);
                exp_up.push_back(slave_resp[int'(wr) + i]);
            end
        end
        mosi_q.delete();
        upload_q.delete();
        falls0 = cs_falls;
        stall_mode = (stall != 0);

        @(posedge clk);
        #1;
        i_cmd_type   = op;
        i_cmd_length = 16'(nw + 2);
        i_cmd_start  = 1'b1;
        @(posedge clk);
        #1 i_cmd_start = 1'b0;
        for (i = 0; i < nw + 2; i++) begin
            i_cmd_data_index = 16'(i);
            i_cmd_data       = (i == 0) ? wr : ((i == 1) ? rd : wbytes[i-2]);
            i_cmd_data_valid = 1'b1;
            @(posedge clk);
            #1 i_cmd_data_valid = 1'b0;
        end
        i_cmd_done = 1'b1;
        @(posedge clk);
        #1 i_cmd_done = 1'b0;
        if (op == SPI_OPCODE)
            check_value("cmd ready in parse", 32'd0, 32'(o_cmd_ready));
        wait_cmd_ready(ok);
        stall_mode = 1'b0;
        if (!ok)
            return;

        check_value("cs frames", (valid && (wr + rd != 8'd0)) ? 32'd1 : 32'd0,
                    32'(cs_falls - falls0));
        check_value("mosi count", 32'(exp_mosi.size()), 32'(mosi_q.size()));
        for (i = 0; i < exp_mosi.size() && i < mosi_q.size(); i++)
            check_value($sformatf("mosi byte %0d", i), 32'(exp_mosi[i]), 32'(mosi_q[i]));
        check_value("upload count", 32'(exp_up.size()), 32'(upload_q.size()));
        for (i = 0; i < exp_up.size() && i < upload_q.size(); i++)
            check_value($sformatf("upload byte %0d", i), 32'(exp_up[i]), 32'(upload_q[i]));
        check_value("upload active at end", 32'd0, 32'(o_upload_active));
    endtask

    initial begin
        int           fd;
        int           n;
        string        line;
        string        name;
        logic [7:0]   op;
        logic [7:0]   wr;
        logic [7:0]   rd;
        logic [127:0] wdata;
        logic [127:0] rdata;
        int           stall;
        i_cmd_type       = 8'h00;
        i_cmd_length     = 16'h0000;
        i_cmd_start      = 1'b0;
        i_cmd_data       = 8'h00;
        i_cmd_data_index = 16'h0000;
        i_cmd_data_valid = 1'b0;
        i_cmd_done       = 1'b0;
        i_upload_ready   = 1'b1;
        for (n = 0; n < 32; n++)
            slave_resp[n] = 8'h00;

        for (n = 0; n < 20 && rst_n !== 1'b1; n++)
            @(posedge clk);
        if (rst_n !== 1'b1) begin
            $display("timeout, reset was never released");
            errors++;
        end else begin
            check_value("cs_n idle", 32'd1, 32'(o_spi_cs_n));
            check_value("sclk idle", 32'd0, 32'(o_spi_clk));
            check_value("upload valid idle", 32'd0, 32'(o_upload_valid));
            check_value("upload active idle", 32'd0, 32'(o_upload_active));
            check_value("cmd ready idle", 32'd1, 32'(o_cmd_ready));

            fd = $fopen("bench/spi_input_vectors.txt", "r");
            if (fd == 0) begin
                $display("could not open the vector file");
                errors++;
            end else begin
                while (!$feof(fd) && !timed_out) begin
                    if ($fgets(line, fd) == 0)
                        break;
                    if (line.len() < 2 || line.substr(0, 0) == "#")
                        continue;  // comment or blank
                    n = $sscanf(line, "%s %h %h %h %h %h %d",
                                name, op, wr, rd, wdata, rdata, stall);
                    if (n != 7) begin
                        $display("malformed vector line: %s", line);
                        errors++;
                        continue;
                    end
                    test_name = name;
                    run_vector(op, wr, rd, wdata, rdata, stall);
                end
                $fclose(fd);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end
endmodule

//--- include/spi_bridge_cfg.svh
`ifndef SPI_BRIDGE_CFG_SVH
`define SPI_BRIDGE_CFG_SVH

// bytes held by each of the tx and rx buffers
`define SPI_BUF_DEPTH 16

// system clocks per half period of sclk
`define SPI_CLK_DIV 2

`endif

//--- run.sh
#!/bin/bash
# build and run the spi bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_spi_bridge -o sim_spi_bridge
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_spi_bridge)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1

//--- source/bridge_cmd_pkg.sv
package bridge_cmd_pkg;

    // opcode routed to the spi bridge
    localparam logic [7:0] CMD_SPI_WRITE = 8'h11;

    // tag carried on every upload byte
    localparam logic [7:0] UPLOAD_SOURCE_SPI = 8'h03;

    // payload header layout
    localparam int HDR_BYTES      = 2;
    localparam int HDR_WR_LEN_IDX = 0;  // write length byte
    localparam int HDR_RD_LEN_IDX = 1;  // read length byte

endpackage

//--- source/spi_bridge.sv
`timescale 1ns/10ps
`include "spi_bridge_cfg.svh"

module spi_bridge (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  i_cmd_type,
    input  logic [15:0] i_cmd_length,
    input  logic        i_cmd_start,
    input  logic [7:0]  i_cmd_data,
    input  logic [15:0] i_cmd_data_index,
    input  logic        i_cmd_data_valid,
    input  logic        i_cmd_done,
    output logic        o_cmd_ready,
    output logic        o_spi_clk,
    output logic        o_spi_cs_n,
    output logic        o_spi_mosi,
    input  logic        i_spi_miso,
    input  logic        i_upload_ready,
    output logic        o_upload_valid,
    output logic [7:0]  o_upload_data,
    output logic [7:0]  o_upload_source,
    output logic        o_upload_active
);
    localparam int ADDR_W = $clog2(`SPI_BUF_DEPTH);

    logic              xfer_start;
    logic              xfer_done;
    logic [7:0]        wr_len;
    logic [7:0]        rd_len;
    logic [ADDR_W-1:0] tx_rd_index;
    logic [7:0]        tx_rd_byte;
    logic [ADDR_W-1:0] rx_rd_index;
    logic [7:0]        rx_rd_byte;
    logic              rx_ready;
    logic [7:0]        rx_len;
    logic              upload_finish;
    logic              busy_done;

    // write only commands end at the transfer, others after the upload
    assign busy_done = upload_finish | (xfer_done & (rd_len == 8'd0));

    spi_cmd_collector u_collector (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_cmd_type       (i_cmd_type),
        .i_cmd_length     (i_cmd_length),
        .i_cmd_start      (i_cmd_start),
        .i_cmd_data       (i_cmd_data),
        .i_cmd_data_index (i_cmd_data_index),
        .i_cmd_data_valid (i_cmd_data_valid),
        .i_cmd_done       (i_cmd_done),
        .i_busy_done      (busy_done),
        .i_tx_rd_index    (tx_rd_index),
        .o_tx_rd_byte     (tx_rd_byte),
        .o_cmd_ready      (o_cmd_ready),
        .o_xfer_start     (xfer_start),
        .o_wr_len         (wr_len),
        .o_rd_len         (rd_len)
    );

    spi_transfer_seq u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_xfer_start  (xfer_start),
        .i_wr_len      (wr_len),
        .i_rd_len      (rd_len),
        .o_tx_rd_index (tx_rd_index),
        .i_tx_rd_byte  (tx_rd_byte),
        .i_rx_rd_index (rx_rd_index),
        .o_rx_rd_byte  (rx_rd_byte),
        .o_rx_ready    (rx_ready),
        .o_rx_len      (rx_len),
        .o_xfer_done   (xfer_done),
        .o_spi_cs_n    (o_spi_cs_n),
        .o_spi_clk     (o_spi_clk),
        .o_spi_mosi    (o_spi_mosi),
        .i_spi_miso    (i_spi_miso)
    );

    spi_rx_uploader u_uploader (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_rx_ready      (rx_ready),
        .i_rx_len        (rx_len),
        .o_rx_rd_index   (rx_rd_index),
        .i_rx_rd_byte    (rx_rd_byte),
        .i_upload_ready  (i_upload_ready),
        .o_upload_valid  (o_upload_valid),
        .o_upload_data   (o_upload_data),
        .o_upload_source (o_upload_source),
        .o_upload_active (o_upload_active),
        .o_upload_finish (upload_finish)
    );

endmodule

//--- source/spi_byte_shifter.sv
`timescale 1ns/10ps
`include "spi_bridge_cfg.svh"

module spi_byte_shifter #(
    parameter int DIV_W = $clog2(`SPI_CLK_DIV + 1)
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_start,
    input  logic [7:0] i_tx_byte,
    input  logic       i_cs_active,
    output logic [7:0] o_rx_byte,
    output logic       o_done,
    output logic       o_spi_clk,
    output logic       o_spi_mosi,
    input  logic       i_spi_miso
);
    logic             active;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       edge_cnt;  // 16 sclk edges per byte
    logic             sclk;
    logic             toggle;
    logic [7:0]       tx_sreg;
    logic [7:0]       rx_sreg;

    assign toggle = active && (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));

    assign o_spi_clk  = sclk;
    assign o_spi_mosi = i_cs_active & tx_sreg[7];  // msb first, idle low
    assign o_rx_byte  = rx_sreg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= 4'd0;
            sclk     <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start && !active) begin
                active   <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= 4'd0;
            end else if (toggle) begin
                div_cnt  <= '0;
                sclk     <= !sclk;
                edge_cnt <= edge_cnt + 4'd1;
                if (edge_cnt == 4'd15) begin  // last falling edge
                    active <= 1'b0;
                    o_done <= 1'b1;
                end
            end else if (active) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start && !active)
            tx_sreg <= i_tx_byte;
        else if (toggle && sclk)
            tx_sreg <= {tx_sreg[6:0], 1'b0};  // falling edge shifts next bit out
        if (toggle && !sclk)
            rx_sreg <= {rx_sreg[6:0], i_spi_miso};  // sample on rising edge
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        active |-> !i_start)
        else $error("byte start while shifter busy");

endmodule

//--- source/spi_cmd_collector.sv
`timescale 1ns/10ps
`include "spi_bridge_cfg.svh"

module spi_cmd_collector
    import bridge_cmd_pkg::*, spi_seq_pkg::*;
#(
    parameter int ADDR_W = $clog2(`SPI_BUF_DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [7:0]        i_cmd_type,
    input  logic [15:0]       i_cmd_length,
    input  logic              i_cmd_start,
    input  logic [7:0]        i_cmd_data,
    input  logic [15:0]       i_cmd_data_index,
    input  logic              i_cmd_data_valid,
    input  logic              i_cmd_done,
    input  logic              i_busy_done,
    input  logic [ADDR_W-1:0] i_tx_rd_index,
    output logic [7:0]        o_tx_rd_byte,
    output logic              o_cmd_ready,
    output logic              o_xfer_start,
    output logic [7:0]        o_wr_len,
    output logic [7:0]        o_rd_len
);
    localparam int DEPTH = `SPI_BUF_DEPTH;

    logic [1:0]      state;
    logic            busy;  // transfer or upload still running
    logic [7:0]      tx_buf [DEPTH];
    logic [8:0]      hdr_wr_end;
    logic            hdr_ok;
    logic [ADDR_W:0] rd_addr;

    // header plus write data must fit, read data must fit
    assign hdr_wr_end = {1'b0, tx_buf[HDR_WR_LEN_IDX]} + 9'(HDR_BYTES);
    assign hdr_ok = (hdr_wr_end <= 9'(DEPTH)) && ({1'b0, tx_buf[HDR_RD_LEN_IDX]} <= 9'(DEPTH));

    assign rd_addr = {1'b0, i_tx_rd_index} + (ADDR_W + 1)'(HDR_BYTES);  // skip header
    assign o_tx_rd_byte = (rd_addr < (ADDR_W + 1)'(DEPTH)) ? tx_buf[rd_addr[ADDR_W-1:0]] : 8'h00;

    assign o_cmd_ready = (state == COL_COLLECT) || ((state == COL_IDLE) && !busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= COL_IDLE;
            busy         <= 1'b0;
            o_xfer_start <= 1'b0;
            o_wr_len     <= 8'h00;
            o_rd_len     <= 8'h00;
        end else begin
            o_xfer_start <= 1'b0;
            if (i_busy_done)
                busy <= 1'b0;
            case (state)
                COL_IDLE: begin
                    if (i_cmd_start && !busy && (i_cmd_type == CMD_SPI_WRITE) &&
                        (i_cmd_length >= 16'd2))
                        state <= COL_COLLECT;
                end
                COL_COLLECT: begin
                    if (i_cmd_done)
                        state <= COL_PARSE;
                end
                COL_PARSE: begin
                    if (hdr_ok) begin
                        o_wr_len     <= tx_buf[HDR_WR_LEN_IDX];
                        o_rd_len     <= tx_buf[HDR_RD_LEN_IDX];
                        o_xfer_start <= 1'b1;
                        busy         <= 1'b1;
                    end
                    state <= COL_IDLE;  // bad header is dropped silently
                end
                default: state <= COL_IDLE;
            endcase
        end
    end

    // out of range indices are ignored
    always_ff @(posedge clk) begin
        if ((state == COL_COLLECT) && i_cmd_data_valid && (i_cmd_data_index < 16'(DEPTH)))
            tx_buf[i_cmd_data_index[ADDR_W-1:0]] <= i_cmd_data;
    end

    // one transaction at a time until the downstream side reports done
    a_single_xfer: assert property (@(posedge clk) disable iff (!rst_n)
        o_xfer_start |=> (!o_xfer_start until_with i_busy_done))
        else $error("xfer_start issued while previous transfer busy");

endmodule

//--- source/spi_rx_uploader.sv
`timescale 1ns/10ps
`include "spi_bridge_cfg.svh"

module spi_rx_uploader
    import bridge_cmd_pkg::*, spi_seq_pkg::*;
#(
    parameter int ADDR_W = $clog2(`SPI_BUF_DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_rx_ready,
    input  logic [7:0]        i_rx_len,
    output logic [ADDR_W-1:0] o_rx_rd_index,
    input  logic [7:0]        i_rx_rd_byte,
    input  logic              i_upload_ready,
    output logic              o_upload_valid,
    output logic [7:0]        o_upload_data,
    output logic [7:0]        o_upload_source,
    output logic              o_upload_active,
    output logic              o_upload_finish
);
    logic [1:0] state;
    logic [7:0] idx;
    logic [7:0] len;
    logic       gap_cnt;  // two idle cycles after each byte

    // byte stays put while ready is low
    assign o_upload_valid  = (state == UP_SEND) && i_upload_ready;
    assign o_rx_rd_index   = idx[ADDR_W-1:0];
    assign o_upload_data   = i_rx_rd_byte;
    assign o_upload_source = UPLOAD_SOURCE_SPI;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= UP_IDLE;
            idx             <= 8'd0;
            len             <= 8'd0;
            gap_cnt         <= 1'b0;
            o_upload_active <= 1'b0;
            o_upload_finish <= 1'b0;
        end else begin
            o_upload_finish <= 1'b0;
            case (state)
                UP_IDLE: begin
                    if (i_rx_ready) begin
                        len             <= i_rx_len;
                        idx             <= 8'd0;
                        o_upload_active <= 1'b1;
                        state           <= UP_SEND;
                    end
                end
                UP_SEND: begin
                    if (i_upload_ready) begin
                        idx     <= idx + 8'd1;
                        gap_cnt <= 1'b0;
                        state   <= UP_GAP;
                    end
                end
                UP_GAP: begin
                    if (!gap_cnt) begin
                        gap_cnt <= 1'b1;
                    end else if (idx == len) begin
                        o_upload_active <= 1'b0;
                        o_upload_finish <= 1'b1;
                        state           <= UP_IDLE;
                    end else begin
                        state <= UP_SEND;
                    end
                end
                default: state <= UP_IDLE;
            endcase
        end
    end

    a_upload_pace: assert property (@(posedge clk) disable iff (!rst_n)
        o_upload_valid |=> (!o_upload_valid ##1 !o_upload_valid))
        else $error("upload pulses closer than three cycles");

endmodule

//--- source/spi_seq_pkg.sv
package spi_seq_pkg;

    // command collector
    localparam logic [1:0] COL_IDLE    = 2'd0;
    localparam logic [1:0] COL_COLLECT = 2'd1;
    localparam logic [1:0] COL_PARSE   = 2'd2;

    // transfer sequencer
    localparam logic [1:0] SEQ_IDLE   = 2'd0;
    localparam logic [1:0] SEQ_ISSUE  = 2'd1;
    localparam logic [1:0] SEQ_WAIT   = 2'd2;
    localparam logic [1:0] SEQ_FINISH = 2'd3;

    // rx uploader
    localparam logic [1:0] UP_IDLE = 2'd0;
    localparam logic [1:0] UP_SEND = 2'd1;
    localparam logic [1:0] UP_GAP  = 2'd2;

endpackage

//--- source/spi_transfer_seq.sv
`timescale 1ns/10ps
`include "spi_bridge_cfg.svh"

module spi_transfer_seq
    import bridge_cmd_pkg::*, spi_seq_pkg::*;
#(
    parameter int ADDR_W = $clog2(`SPI_BUF_DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_xfer_start,
    input  logic [7:0]        i_wr_len,
    input  logic [7:0]        i_rd_len,
    output logic [ADDR_W-1:0] o_tx_rd_index,
    input  logic [7:0]        i_tx_rd_byte,
    input  logic [ADDR_W-1:0] i_rx_rd_index,
    output logic [7:0]        o_rx_rd_byte,
    output logic              o_rx_ready,
    output logic [7:0]        o_rx_len,
    output logic              o_xfer_done,
    output logic              o_spi_cs_n,
    output logic              o_spi_clk,
    output logic              o_spi_mosi,
    input  logic              i_spi_miso
);
    localparam int DEPTH = `SPI_BUF_DEPTH;

    logic [1:0] state;
    logic [7:0] byte_idx;  // position in the whole transaction
    logic [8:0] total;
    logic       in_write;
    logic       tx_in_buf;
    logic [7:0] rx_idx;
    logic       byte_start;
    logic [7:0] byte_tx;
    logic       byte_done;
    logic [7:0] byte_rx;
    logic [7:0] rx_buf [DEPTH];

    assign total     = {1'b0, i_wr_len} + {1'b0, i_rd_len};
    assign in_write  = byte_idx < i_wr_len;
    assign tx_in_buf = byte_idx < 8'(DEPTH - HDR_BYTES);
    assign rx_idx    = byte_idx - i_wr_len;

    assign o_tx_rd_index = byte_idx[ADDR_W-1:0];
    assign o_rx_rd_byte  = rx_buf[i_rx_rd_index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SEQ_IDLE;
            byte_idx    <= 8'd0;
            o_spi_cs_n  <= 1'b1;
            byte_start  <= 1'b0;
            byte_tx     <= 8'h00;
            o_xfer_done <= 1'b0;
            o_rx_ready  <= 1'b0;
            o_rx_len    <= 8'd0;
        end else begin
            byte_start  <= 1'b0;
            o_xfer_done <= 1'b0;
            o_rx_ready  <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (i_xfer_start) begin
                        byte_idx <= 8'd0;
                        if (total == 9'd0) begin
                            state <= SEQ_FINISH;  // empty transaction, cs stays high
                        end else begin
                            o_spi_cs_n <= 1'b0;
                            state      <= SEQ_ISSUE;
                        end
                    end
                end
                SEQ_ISSUE: begin
                    byte_tx    <= (in_write && tx_in_buf) ? i_tx_rd_byte : 8'h00;
                    byte_start <= 1'b1;
                    state      <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (byte_done) begin
                        byte_idx <= byte_idx + 8'd1;
                        state    <= ({1'b0, byte_idx} + 9'd1 == total) ? SEQ_FINISH : SEQ_ISSUE;
                    end
                end
                SEQ_FINISH: begin
                    o_spi_cs_n  <= 1'b1;
                    o_xfer_done <= 1'b1;
                    o_rx_ready  <= (i_rd_len != 8'd0);
                    o_rx_len    <= i_rd_len;
                    state       <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // read phase bytes land at offset zero
    always_ff @(posedge clk) begin
        if ((state == SEQ_WAIT) && byte_done && !in_write && (rx_idx < 8'(DEPTH)))
            rx_buf[rx_idx[ADDR_W-1:0]] <= byte_rx;
    end

    spi_byte_shifter u_shifter (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_start     (byte_start),
        .i_tx_byte   (byte_tx),
        .i_cs_active (!o_spi_cs_n),
        .o_rx_byte   (byte_rx),
        .o_done      (byte_done),
        .o_spi_clk   (o_spi_clk),
        .o_spi_mosi  (o_spi_mosi),
        .i_spi_miso  (i_spi_miso)
    );

    a_cs_framed: assert property (@(posedge clk) disable iff (!rst_n)
        (o_spi_clk || byte_done) |-> !o_spi_cs_n)
        else $error("sclk activity outside chip select");

endmodule

//--- verilog.f
+incdir+include
source/bridge_cmd_pkg.sv
source/spi_seq_pkg.sv
source/spi_cmd_collector.sv
source/spi_byte_shifter.sv
source/spi_transfer_seq.sv
source/spi_rx_uploader.sv
source/spi_bridge.sv
bench/tb_clock_gen.sv
bench/tb_spi_bridge.sv
